/* source/video_pkg.sv */
`default_nettype none

package video_pkg;

  // raster geometry, kept tiny so a frame simulates fast
  localparam int H_ACTIVE = 8;
  localparam int H_BLANK  = 4;
  localparam int V_ACTIVE = 4;
  localparam int V_BLANK  = 2;

  // sync widths, counted from the start of blanking
  localparam int H_SYNC   = 2;
  localparam int V_SYNC   = 1;

  localparam int H_TOTAL  = H_ACTIVE + H_BLANK;
  localparam int V_TOTAL  = V_ACTIVE + V_BLANK;

  // counter widths for column and line
  localparam int H_CW     = $clog2(H_TOTAL);
  localparam int V_CW     = $clog2(V_TOTAL);

  // one bank holds one active line
  localparam int BANK_AW  = 3;

  // register map, byte offsets
  localparam logic [3:0]  REG_CONTROL = 4'h0;
  localparam logic [3:0]  REG_STATUS  = 4'h4;
  localparam logic [3:0]  REG_PIXEL   = 4'h8;
  localparam logic [3:0]  REG_VERSION = 4'hC;

  localparam logic [31:0] VERSION_ID  = 32'h5644_0001;

  // axi response codes
  localparam logic [1:0]  RESP_OKAY   = 2'b00;
  localparam logic [1:0]  RESP_SLVERR = 2'b10;

  // red in the top byte, blue in the bottom
  typedef struct packed {
    logic [7:0] red;
    logic [7:0] green;
    logic [7:0] blue;
  } rgb_t;

  typedef struct packed {
    logic hsync;
    logic vsync;
    logic de;
    rgb_t rgb;
  } video_t;

  // master to slave
  typedef struct packed {
    logic [3:0]  awaddr;
    logic        awvalid;
    logic [31:0] wdata;
    logic [3:0]  wstrb;
    logic        wvalid;
    logic        bready;
    logic [3:0]  araddr;
    logic        arvalid;
    logic        rready;
  } axil_req_t;

  // slave to master
  typedef struct packed {
    logic        awready;
    logic        wready;
    logic [1:0]  bresp;
    logic        bvalid;
    logic        arready;
    logic [31:0] rdata;
    logic [1:0]  rresp;
    logic        rvalid;
  } axil_rsp_t;

endpackage

`default_nettype wire

/* source/video_regs.sv */
`timescale 1ns/1ps
`default_nettype none

module video_regs (
  input  wire logic                  clk,
  input  wire logic                  rst,
  input  wire video_pkg::axil_req_t  i_axil,
  output video_pkg::axil_rsp_t       o_axil,
  input  wire logic [1:0]            i_wr_rdy,
  output logic [1:0]                 o_wr_act,
  output logic                       o_wr_stb,
  output video_pkg::rgb_t            o_wr_data,
  input  wire logic                  i_read_full,
  input  wire logic                  i_underrun,
  output logic                       o_enable
);
  import video_pkg::*;

  logic               wr_fire;
  logic               wr_pixel;
  logic               wr_ok;
  logic               rd_fire;
  logic               push_room;
  logic               wr_free;
  logic               wr_sel;
  logic [BANK_AW:0]   wr_cnt;
  logic               underrun;
  logic               bvalid;
  logic [1:0]         bresp;
  logic               rvalid;
  logic [1:0]         rresp;
  logic [31:0]        rdata;

  function automatic logic addr_known(input logic [3:0] addr);
    return (addr == REG_CONTROL) || (addr == REG_STATUS) ||
           (addr == REG_PIXEL) || (addr == REG_VERSION);
  endfunction

  // open bank with words still to fill
  assign push_room = (o_wr_act != 2'b00) && (wr_cnt < (BANK_AW + 1)'(H_ACTIVE));
  assign wr_free   = push_room || (i_wr_rdy != 2'b00);

  // pixel writes stall until a bank can take them
  assign wr_ok    = (i_axil.awaddr != REG_PIXEL) || push_room;
  assign wr_fire  = i_axil.awvalid && i_axil.wvalid && !bvalid && wr_ok;
  assign wr_pixel = wr_fire && (i_axil.awaddr == REG_PIXEL);
  assign rd_fire  = i_axil.arvalid && !rvalid;

  always_comb begin
    o_axil.awready = wr_fire;
    o_axil.wready  = wr_fire;
    o_axil.bresp   = bresp;
    o_axil.bvalid  = bvalid;
    o_axil.arready = rd_fire;
    o_axil.rdata   = rdata;
    o_axil.rresp   = rresp;
    o_axil.rvalid  = rvalid;
  end

  // write response, control and sticky status
  always_ff @(posedge clk) begin
    if (rst) begin
      bvalid   <= 1'b0;
      bresp    <= RESP_OKAY;
      o_enable <= 1'b0;
      underrun <= 1'b0;
    end else begin
      if (wr_fire) begin
        bvalid <= 1'b1;
        bresp  <= addr_known(i_axil.awaddr) ? RESP_OKAY : RESP_SLVERR;
      end else if (i_axil.bready) begin
        bvalid <= 1'b0;
      end
      if (wr_fire && (i_axil.awaddr == REG_CONTROL) && i_axil.wstrb[0]) begin
        o_enable <= i_axil.wdata[0];
      end
      // a new underrun beats a clear in the same cycle
      if (i_underrun) begin
        underrun <= 1'b1;
      end else if (wr_fire && (i_axil.awaddr == REG_STATUS) && i_axil.wstrb[0] &&
                   i_axil.wdata[0]) begin
        underrun <= 1'b0;
      end
    end
  end

  // read response
  always_ff @(posedge clk) begin
    if (rst) begin
      rvalid <= 1'b0;
      rresp  <= RESP_OKAY;
    end else if (rd_fire) begin
      rvalid <= 1'b1;
      rresp  <= addr_known(i_axil.araddr) ? RESP_OKAY : RESP_SLVERR;
    end else if (i_axil.rready) begin
      rvalid <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (rd_fire) begin
      case (i_axil.araddr)
        REG_CONTROL: rdata <= {31'd0, o_enable};
        REG_STATUS:  rdata <= {29'd0, i_read_full, wr_free, underrun};
        REG_VERSION: rdata <= VERSION_ID;
        // pixel port is write only
        default:     rdata <= '0;
      endcase
    end
  end

  // bank open, count, close; banks alternate
  always_ff @(posedge clk) begin
    o_wr_stb <= 1'b0;
    if (rst) begin
      o_wr_act <= 2'b00;
      wr_sel   <= 1'b0;
      wr_cnt   <= '0;
    end else begin
      if (o_wr_act == 2'b00) begin
        if (i_wr_rdy[wr_sel]) begin
          o_wr_act[wr_sel] <= 1'b1;
          wr_cnt           <= '0;
        end
      end else if (wr_cnt == (BANK_AW + 1)'(H_ACTIVE)) begin
        // last word lands this edge, then the bank is full
        o_wr_act <= 2'b00;
        wr_sel   <= ~wr_sel;
      end
      if (wr_pixel) begin
        o_wr_stb <= 1'b1;
        wr_cnt   <= wr_cnt + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (wr_pixel) begin
      o_wr_data <= i_axil.wdata[23:0];
    end
  end

endmodule

`default_nettype wire

/* source/ppfifo.sv */
`timescale 1ns/1ps
`default_nettype none

module ppfifo (
  input  wire logic                     clk,
  input  wire logic                     rst,
  output logic [1:0]                    o_wr_rdy,
  input  wire logic [1:0]               i_wr_act,
  input  wire logic                     i_wr_stb,
  input  wire video_pkg::rgb_t          i_wr_data,
  output logic                          o_read_rdy,
  input  wire logic                     i_read_act,
  output logic [video_pkg::BANK_AW:0]   o_read_size,
  output video_pkg::rgb_t               o_read_data,
  input  wire logic                     i_read_stb
);
  import video_pkg::*;

  typedef enum logic [1:0] {
    BANK_FREE,
    BANK_WRITING,
    BANK_FULL,
    BANK_READING
  } bank_state_t;

  bank_state_t        state    [2];
  logic [BANK_AW:0]   fill_cnt [2];
  rgb_t               mem      [2][H_ACTIVE];
  logic [1:0]         wr_en;
  // oldest full bank, also the one being read
  logic               rd_sel;
  logic [BANK_AW-1:0] rd_idx;

  always_comb begin
    for (int b = 0; b < 2; b++) begin
      o_wr_rdy[b] = (state[b] == BANK_FREE);
      // drop pushes beyond the bank depth
      wr_en[b]    = (state[b] == BANK_WRITING) && i_wr_act[b] && i_wr_stb &&
                    (fill_cnt[b] < (BANK_AW + 1)'(H_ACTIVE));
    end
  end

  // first word falls through
  assign o_read_rdy  = (state[rd_sel] == BANK_FULL);
  assign o_read_size = fill_cnt[rd_sel];
  assign o_read_data = mem[rd_sel][rd_idx];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int b = 0; b < 2; b++) begin
        state[b]    <= BANK_FREE;
        fill_cnt[b] <= '0;
      end
      rd_sel <= 1'b0;
      rd_idx <= '0;
    end else begin
      for (int b = 0; b < 2; b++) begin
        case (state[b])
          BANK_FREE: begin
            if (i_wr_act[b]) begin
              state[b]    <= BANK_WRITING;
              fill_cnt[b] <= '0;
            end
          end
          BANK_WRITING: begin
            if (wr_en[b]) begin
              fill_cnt[b] <= fill_cnt[b] + 1'b1;
            end
            // writer let go
            if (!i_wr_act[b]) begin
              state[b] <= BANK_FULL;
            end
          end
          BANK_FULL: begin
            if (i_read_act && (rd_sel == 1'(b))) begin
              state[b] <= BANK_READING;
            end
          end
          default: begin
            if (!i_read_act) begin
              state[b] <= BANK_FREE;
            end
          end
        endcase
      end

      // read pointer, moves to the other bank on release
      if (state[rd_sel] == BANK_READING) begin
        if (!i_read_act) begin
          rd_sel <= ~rd_sel;
          rd_idx <= '0;
        end else if (i_read_stb) begin
          rd_idx <= rd_idx + 1'b1;
        end
      end
    end
  end

  // bank storage
  always_ff @(posedge clk) begin
    for (int b = 0; b < 2; b++) begin
      if (wr_en[b]) begin
        mem[b][fill_cnt[b][BANK_AW-1:0]] <= i_wr_data;
      end
    end
  end

endmodule

`default_nettype wire

/* source/pixel_reader.sv */
`timescale 1ns/1ps
`default_nettype none

module pixel_reader (
  input  wire logic                     clk,
  input  wire logic                     rst,
  input  wire logic                     i_read_rdy,
  output logic                          o_read_act,
  input  wire logic [video_pkg::BANK_AW:0] i_read_size,
  input  wire video_pkg::rgb_t          i_read_data,
  output logic                          o_read_stb,
  output video_pkg::rgb_t               o_pixel,
  output logic                          o_pixel_rdy,
  input  wire logic                     i_pixel_stb
);
  import video_pkg::*;

  logic [BANK_AW:0] read_count;
  logic             can_load;

  // slot free, bank open, words left
  assign can_load = !o_pixel_rdy && o_read_act && (read_count < i_read_size);

  always_ff @(posedge clk) begin
    o_read_stb <= 1'b0;
    if (rst) begin
      o_read_act  <= 1'b0;
      o_pixel_rdy <= 1'b0;
      read_count  <= '0;
    end else begin
      // claim a waiting bank
      if (i_read_rdy && !o_read_act) begin
        read_count <= '0;
        o_read_act <= 1'b1;
      end

      if (can_load) begin
        read_count  <= read_count + 1'b1;
        o_read_stb  <= 1'b1;
        o_pixel_rdy <= 1'b1;
      end else if (o_pixel_rdy && i_pixel_stb) begin
        o_pixel_rdy <= 1'b0;
      end

      // whole bank read, hand it back
      if (o_read_act && (read_count >= i_read_size)) begin
        o_read_act <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (can_load) begin
      o_pixel <= i_read_data;
    end
  end

endmodule

`default_nettype wire

/* source/video_timing.sv */
`timescale 1ns/1ps
`default_nettype none

module video_timing (
  input  wire logic             clk,
  input  wire logic             rst,
  input  wire logic             i_enable,
  input  wire video_pkg::rgb_t  i_pixel,
  input  wire logic             i_pixel_rdy,
  output logic                  o_pixel_stb,
  output logic                  o_underrun,
  output video_pkg::video_t     o_video
);
  import video_pkg::*;

  logic            phase;
  logic            slot;
  logic [H_CW-1:0] col;
  logic [V_CW-1:0] line;
  logic            active;
  logic            hsync;
  logic            vsync;

  // one pixel slot every second cycle
  assign slot   = i_enable && phase;

  assign active = (col < H_CW'(H_ACTIVE)) && (line < V_CW'(V_ACTIVE));
  assign hsync  = (col >= H_CW'(H_ACTIVE)) && (col < H_CW'(H_ACTIVE + H_SYNC));
  assign vsync  = (line >= V_CW'(V_ACTIVE)) && (line < V_CW'(V_ACTIVE + V_SYNC));

  // take the offered pixel, or flag a miss
  assign o_pixel_stb = slot && active && i_pixel_rdy;
  assign o_underrun  = slot && active && !i_pixel_rdy;

  // slot divider, column and line counters
  always_ff @(posedge clk) begin
    if (rst || !i_enable) begin
      phase <= 1'b0;
      col   <= '0;
      line  <= '0;
    end else begin
      phase <= ~phase;
      if (slot) begin
        if (col == H_CW'(H_TOTAL - 1)) begin
          col <= '0;
          if (line == V_CW'(V_TOTAL - 1)) begin
            line <= '0;
          end else begin
            line <= line + 1'b1;
          end
        end else begin
          col <= col + 1'b1;
        end
      end
    end
  end

  // output held for both cycles of a slot
  always_ff @(posedge clk) begin
    if (rst || !i_enable) begin
      o_video <= '0;
    end else if (slot) begin
      o_video.hsync <= hsync;
      o_video.vsync <= vsync;
      o_video.de    <= active;
      // black in blanking and on underrun
      o_video.rgb   <= (active && i_pixel_rdy) ? i_pixel : '0;
    end
  end

endmodule

`default_nettype wire

/* source/video_out_top.sv */
`timescale 1ns/1ps
`default_nettype none

module video_out_top (
  input  wire logic                  clk,
  input  wire logic                  rst,
  input  wire video_pkg::axil_req_t  i_axil,
  output video_pkg::axil_rsp_t       o_axil,
  output video_pkg::video_t          o_video
);
  import video_pkg::*;

  // register block to fifo
  logic [1:0]       wr_rdy;
  logic [1:0]       wr_act;
  logic             wr_stb;
  rgb_t             wr_data;

  // fifo to reader
  logic             read_rdy;
  logic             read_act;
  logic [BANK_AW:0] read_size;
  rgb_t             read_data;
  logic             read_stb;

  // reader to timing
  rgb_t             pixel;
  logic             pixel_rdy;
  logic             pixel_stb;

  // timing back to registers
  logic             underrun;
  logic             enable;

  video_regs video_regs_i (
    .clk         (clk),
    .rst         (rst),
    .i_axil      (i_axil),
    .o_axil      (o_axil),
    .i_wr_rdy    (wr_rdy),
    .o_wr_act    (wr_act),
    .o_wr_stb    (wr_stb),
    .o_wr_data   (wr_data),
    .i_read_full (read_rdy),
    .i_underrun  (underrun),
    .o_enable    (enable)
  );

  ppfifo ppfifo_i (
    .clk         (clk),
    .rst         (rst),
    .o_wr_rdy    (wr_rdy),
    .i_wr_act    (wr_act),
    .i_wr_stb    (wr_stb),
    .i_wr_data   (wr_data),
    .o_read_rdy  (read_rdy),
    .i_read_act  (read_act),
    .o_read_size (read_size),
    .o_read_data (read_data),
    .i_read_stb  (read_stb)
  );

  pixel_reader pixel_reader_i (
    .clk         (clk),
    .rst         (rst),
    .i_read_rdy  (read_rdy),
    .o_read_act  (read_act),
    .i_read_size (read_size),
    .i_read_data (read_data),
    .o_read_stb  (read_stb),
    .o_pixel     (pixel),
    .o_pixel_rdy (pixel_rdy),
    .i_pixel_stb (pixel_stb)
  );

  video_timing video_timing_i (
    .clk         (clk),
    .rst         (rst),
    .i_enable    (enable),
    .i_pixel     (pixel),
    .i_pixel_rdy (pixel_rdy),
    .o_pixel_stb (pixel_stb),
    .o_underrun  (underrun),
    .o_video     (o_video)
  );

endmodule

`default_nettype wire

/* verification/video_out_props.sv */
`timescale 1ns/1ps
`default_nettype none

module video_out_props (
  input wire logic       clk,
  input wire logic       rst,
  input wire logic       bvalid,
  input wire logic       bready,
  input wire logic       rvalid,
  input wire logic       rready,
  input wire logic       read_act,
  input wire logic       read_stb,
  input wire logic [1:0] wr_act,
  input wire logic       wr_stb
);

  // number of assertion failures seen in this instance
  int fail_count = 0;

  // write response stays up until the master takes it
  bvalid_hold: assert property (@(posedge clk) disable iff (rst)
    (bvalid && !bready) |=> bvalid)
    else begin
      $error("bvalid dropped before bready");
      fail_count++;
    end

  // same for read data
  rvalid_hold: assert property (@(posedge clk) disable iff (rst)
    (rvalid && !rready) |=> rvalid)
    else begin
      $error("rvalid dropped before rready");
      fail_count++;
    end

  // reader only advances a claimed bank
  read_stb_in_act: assert property (@(posedge clk) disable iff (rst)
    read_stb |-> read_act)
    else begin
      $error("read strobe without an active read bank");
      fail_count++;
    end

  // every push lands in an open bank
  push_in_open_bank: assert property (@(posedge clk) disable iff (rst)
    wr_stb |-> (wr_act != 2'b00))
    else begin
      $error("pixel push without an open write bank");
      fail_count++;
    end

endmodule

// register side: axi handshakes and pushes
bind video_regs video_out_props regs_props_i (
  .clk      (clk),
  .rst      (rst),
  .bvalid   (o_axil.bvalid),
  .bready   (i_axil.bready),
  .rvalid   (o_axil.rvalid),
  .rready   (i_axil.rready),
  .read_act (1'b0),
  .read_stb (1'b0),
  .wr_act   (o_wr_act),
  .wr_stb   (o_wr_stb)
);

// fifo side: both activation handshakes
bind ppfifo video_out_props fifo_props_i (
  .clk      (clk),
  .rst      (rst),
  .bvalid   (1'b0),
  .bready   (1'b0),
  .rvalid   (1'b0),
  .rready   (1'b0),
  .read_act (i_read_act),
  .read_stb (i_read_stb),
  .wr_act   (i_wr_act),
  .wr_stb   (i_wr_stb)
);

`default_nettype wire

/* verification/video_out_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module video_out_tb;
  import video_pkg::*;

  logic        clk;
  logic        rst;
  axil_req_t   axil_req;
  axil_rsp_t   axil_rsp;
  video_t      video;

  // pushed pixels, oldest first
  logic [23:0] expected_q[$];
  logic [15:0] lfsr;
  int          errors;
  int          tests_run;
  int          tests_failed;
  int          test_errors_start;

  // raster monitor state
  logic        slot_next = 1'b0;
  logic        under_next = 1'b0;
  logic        hs_prev = 1'b0;
  logic        line_vs = 1'b0;
  int          slot_idx = 0;
  int          line_de = 0;
  int          line_hs_pulses = 0;
  int          frame_de_lines = 0;
  int          frame_vs_lines = 0;
  int          frames_done = 0;
  int          underrun_slots = 0;

  video_out_top video_out_top_i (
    .clk    (clk),
    .rst    (rst),
    .i_axil (axil_req),
    .o_axil (axil_rsp),
    .o_video(video)
  );

  always #4 clk = ~clk;

  task automatic check_value(input string name, input logic [31:0] exp,
                             input logic [31:0] got);
    assert (exp == got) else begin
      $display("[FAIL] %0t %s expected 0x%0h got 0x%0h", $time, name, exp, got);
      errors++;
    end
  endtask

  task automatic report_error(input string msg);
    $display("%0t error: %s", $time, msg);
    errors++;
  endtask

  // galois form, taps for x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    logic [15:0] n;
    n = s >> 1;
    if (s[0]) begin
      n = n ^ 16'hB400;
    end
    return n;
  endfunction

  task automatic next_pixel(output logic [23:0] px);
    px = '0;
    for (int i = 0; i < 24; i++) begin
      px   = {px[22:0], lfsr[0]};
      lfsr = lfsr_next(lfsr);
    end
  endtask

  // expected raster position comes from the slot count since enable
  task automatic check_slot();
    int   col;
    int   line;
    logic exp_de;
    logic exp_hs;
    logic exp_vs;
    col    = slot_idx % H_TOTAL;
    line   = (slot_idx / H_TOTAL) % V_TOTAL;
    exp_de = (col < H_ACTIVE) && (line < V_ACTIVE);
    exp_hs = (col >= H_ACTIVE) && (col < H_ACTIVE + H_SYNC);
    exp_vs = (line >= V_ACTIVE) && (line < V_ACTIVE + V_SYNC);
    check_value("o_video.de", 32'(exp_de), 32'(video.de));
    check_value("o_video.hsync", 32'(exp_hs), 32'(video.hsync));
    check_value("o_video.vsync", 32'(exp_vs), 32'(video.vsync));
    if (exp_de && video.de) begin
      if (under_next) begin
        // missed slot shows black
        underrun_slots++;
        check_value("o_video.rgb underrun", 32'h0, 32'(video.rgb));
      end else if (expected_q.size() == 0) begin
        report_error("a pixel was shown although none was pushed");
      end else begin
        check_value("o_video.rgb", 32'(expected_q[0]), 32'(video.rgb));
        void'(expected_q.pop_front());
      end
    end else if (!exp_de) begin
      check_value("o_video.rgb blank", 32'h0, 32'(video.rgb));
    end
    if (video.hsync && !hs_prev) begin
      line_hs_pulses++;
    end
    hs_prev = video.hsync;
    if (video.de) begin
      line_de++;
    end
    if (video.vsync) begin
      line_vs = 1'b1;
    end
    // line and frame totals
    if (col == H_TOTAL - 1) begin
      check_value("de pixels per line", (line < V_ACTIVE) ? H_ACTIVE : 0, line_de);
      check_value("hsync pulses per line", 32'd1, line_hs_pulses);
      if (line_de > 0) begin
        frame_de_lines++;
      end
      if (line_vs) begin
        frame_vs_lines++;
      end
      line_de        = 0;
      line_hs_pulses = 0;
      line_vs        = 1'b0;
      if (line == V_TOTAL - 1) begin
        check_value("de lines per frame", V_ACTIVE, frame_de_lines);
        check_value("vsync lines per frame", 32'd1, frame_vs_lines);
        frame_de_lines = 0;
        frame_vs_lines = 0;
        frames_done++;
      end
    end
    slot_idx++;
  endtask

  // a slot edge follows a cycle with phase high; check what it registered
  always @(negedge clk) begin
    if (slot_next) begin
      check_slot();
    end
    if (rst || !video_out_top_i.enable) begin
      slot_next      = 1'b0;
      under_next     = 1'b0;
      hs_prev        = 1'b0;
      line_vs        = 1'b0;
      slot_idx       = 0;
      line_de        = 0;
      line_hs_pulses = 0;
      frame_de_lines = 0;
      frame_vs_lines = 0;
    end else begin
      slot_next  = video_out_top_i.video_timing_i.phase;
      under_next = video_out_top_i.video_timing_i.o_underrun;
    end
  end

  task automatic axi_write(input logic [3:0] addr, input logic [31:0] data,
                           input int limit, output logic accepted, output logic [1:0] resp);
    int   waited;
    logic got_b;
    accepted = 1'b0;
    got_b    = 1'b0;
    resp     = 2'b00;
    waited   = 0;
    @(posedge clk);
    axil_req.awaddr  <= addr;
    axil_req.awvalid <= 1'b1;
    axil_req.wdata   <= data;
    axil_req.wstrb   <= 4'hF;
    axil_req.wvalid  <= 1'b1;
    axil_req.bready  <= 1'b1;
    while (!accepted && waited < limit) begin
      @(negedge clk);
      if (axil_rsp.awready && axil_rsp.wready) begin
        accepted = 1'b1;
      end else begin
        waited++;
      end
    end
    @(posedge clk);
    axil_req.awvalid <= 1'b0;
    axil_req.wvalid  <= 1'b0;
    if (accepted) begin
      waited = 0;
      while (!got_b && waited < 50) begin
        @(negedge clk);
        if (axil_rsp.bvalid) begin
          got_b = 1'b1;
        end else begin
          waited++;
        end
      end
      if (!got_b) begin
        report_error("write response never arrived");
      end
      resp = axil_rsp.bresp;
      @(posedge clk);
    end
    axil_req.bready <= 1'b0;
  endtask

  task automatic axi_read(input logic [3:0] addr, output logic [31:0] data,
                          output logic [1:0] resp);
    int   waited;
    logic done;
    data   = '0;
    resp   = 2'b00;
    done   = 1'b0;
    waited = 0;
    @(posedge clk);
    axil_req.araddr  <= addr;
    axil_req.arvalid <= 1'b1;
    axil_req.rready  <= 1'b1;
    while (!done && waited < 50) begin
      @(negedge clk);
      if (axil_rsp.arready) begin
        done = 1'b1;
      end else begin
        waited++;
      end
    end
    @(posedge clk);
    axil_req.arvalid <= 1'b0;
    if (!done) begin
      report_error("read address was never accepted");
    end else begin
      done   = 1'b0;
      waited = 0;
      while (!done && waited < 50) begin
        @(negedge clk);
        if (axil_rsp.rvalid) begin
          done = 1'b1;
        end else begin
          waited++;
        end
      end
      if (!done) begin
        report_error("read data never arrived");
      end
      data = axil_rsp.rdata;
      resp = axil_rsp.rresp;
      @(posedge clk);
    end
    axil_req.rready <= 1'b0;
  endtask

  task automatic write_reg(input logic [3:0] addr, input logic [31:0] data);
    logic       ok;
    logic [1:0] resp;
    axi_write(addr, data, 100, ok, resp);
    if (!ok) begin
      report_error("register write was never accepted");
    end
    check_value("bresp", RESP_OKAY, resp);
  endtask

  // scoreboard entry only once the slave has taken the word
  task automatic push_value(input logic [23:0] px, input int limit, output logic ok);
    logic [1:0] resp;
    axi_write(REG_PIXEL, {8'h00, px}, limit, ok, resp);
    if (ok) begin
      expected_q.push_back(px);
    end
  endtask

  task automatic push_line();
    logic [23:0] px;
    logic        ok;
    for (int i = 0; i < H_ACTIVE; i++) begin
      next_pixel(px);
      push_value(px, 400, ok);
      if (!ok) begin
        report_error("pixel push was never accepted");
      end
    end
  endtask

  task automatic wait_frames(input int target);
    int waited;
    waited = 0;
    while (frames_done < target && waited < 2000) begin
      @(posedge clk);
      waited++;
    end
    if (frames_done < target) begin
      report_error("timed out waiting for a complete frame");
    end
  endtask

  task automatic wait_queue_empty();
    int waited;
    waited = 0;
    while (expected_q.size() != 0 && waited < 2000) begin
      @(posedge clk);
      waited++;
    end
    if (expected_q.size() != 0) begin
      report_error("pushed pixels never reached the video output");
    end
  endtask

  task automatic start_test();
    test_errors_start = errors;
  endtask

  task automatic finish_test(input string name);
    tests_run++;
    if (errors == test_errors_start) begin
      $display("test %s: PASS", name);
    end else begin
      tests_failed++;
      $display("test %s: FAIL", name);
    end
  endtask

  initial begin
    logic [31:0] data;
    logic [1:0]  resp;
    logic [23:0] px;
    logic        ok;
    int          start;
    clk      = 1'b0;
    rst      = 1'b1;
    axil_req = '0;
    lfsr     = 16'd16;
    errors   = 0;
    tests_run    = 0;
    tests_failed = 0;
    repeat (16) @(posedge clk);
    rst <= 1'b0;
    repeat (4) @(posedge clk);

    start_test();
    axi_read(REG_CONTROL, data, resp);
    check_value("CONTROL", 32'h0, data);
    check_value("rresp CONTROL", RESP_OKAY, resp);
    // one write bank free, nothing full, no underrun
    axi_read(REG_STATUS, data, resp);
    check_value("STATUS", 32'h2, data);
    axi_read(REG_VERSION, data, resp);
    check_value("VERSION", VERSION_ID, data);
    axi_read(4'h2, data, resp);
    check_value("rresp unknown", RESP_SLVERR, resp);
    finish_test("reset_values");

    start_test();
    start = frames_done;
    write_reg(REG_CONTROL, 32'h1);
    wait_frames(start + 2);
    write_reg(REG_CONTROL, 32'h0);
    finish_test("raster_geometry");

    start_test();
    // the geometry run already missed slots, start from a clear flag
    write_reg(REG_STATUS, 32'h1);
    start = underrun_slots;
    write_reg(REG_CONTROL, 32'h1);
    wait_frames(frames_done + 1);
    if (underrun_slots == start) begin
      report_error("no black underrun pixels seen with an empty FIFO");
    end
    axi_read(REG_STATUS, data, resp);
    check_value("STATUS.underrun set", 32'h1, 32'(data[0]));
    write_reg(REG_CONTROL, 32'h0);
    write_reg(REG_STATUS, 32'h1);
    axi_read(REG_STATUS, data, resp);
    check_value("STATUS.underrun cleared", 32'h0, 32'(data[0]));
    finish_test("underrun");

    start_test();
    push_line();
    push_line();
    start = underrun_slots;
    write_reg(REG_CONTROL, 32'h1);
    wait_queue_empty();
    // both lines waited in the banks, so no slot may go black before they are shown
    check_value("underrun slots while lines queued", 32'(start), 32'(underrun_slots));
    wait_frames(frames_done + 1);
    write_reg(REG_CONTROL, 32'h0);
    finish_test("pixel_order");

    start_test();
    push_line();
    push_line();
    // both banks taken, the next push must stall
    next_pixel(px);
    push_value(px, 20, ok);
    check_value("pixel accepted while FIFO full", 32'h0, 32'(ok));
    write_reg(REG_CONTROL, 32'h1);
    push_value(px, 400, ok);
    check_value("pixel accepted after enable", 32'h1, 32'(ok));
    for (int i = 1; i < H_ACTIVE; i++) begin
      next_pixel(px);
      push_value(px, 400, ok);
      if (!ok) begin
        report_error("pixel push was never accepted");
      end
    end
    wait_queue_empty();
    write_reg(REG_CONTROL, 32'h0);
    finish_test("back_pressure");

    repeat (4) @(posedge clk);
    // bound handshake assertions count their own failures
    errors = errors + video_out_top_i.video_regs_i.regs_props_i.fail_count +
             video_out_top_i.ppfifo_i.fifo_props_i.fail_count;
    $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

  // whole-run limit
  initial begin
    repeat (100000) @(posedge clk);
    $display("simulation ran too long, stopping");
    $display("Test failures found");
    $finish;
  end

endmodule

`default_nettype wire

/* sources.f */
source/video_pkg.sv
source/video_regs.sv
source/ppfifo.sv
source/pixel_reader.sv
source/video_timing.sv
source/video_out_top.sv
verification/video_out_props.sv
verification/video_out_tb.sv

/* Makefile */
# Verilator build for the video output subsystem

SIM       := verilator
TOP       := video_out_tb
FILELIST  := sources.f
FLAGS     := --timing --assert
OBJ_DIR   := obj_dir
LOG       := sim.log
PASS_TEXT := All tests passed!

.PHONY: all lint sim clean

all: sim

lint:
	$(SIM) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

$(OBJ_DIR)/V$(TOP): $(FILELIST)
	$(SIM) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

sim: $(OBJ_DIR)/V$(TOP)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_TEXT)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
